/* src/fetch_pkg.sv */
package fetch_pkg;

    ////////////////////////////////////////
    // Memory geometry
    ////////////////////////////////////////

    // Word index width of the instruction SRAM
    localparam int IMEM_AW = 8;

    // Number of 32-bit words in the SRAM
    localparam int IMEM_DEPTH = 1 << IMEM_AW;

    ////////////////////////////////////////
    // Vector types
    ////////////////////////////////////////

    // Byte address of an instruction
    typedef logic [31:0] pc_t;

    // Raw instruction word
    typedef logic [31:0] inst_t;

    // Performance counter value, wraps on overflow
    typedef logic [31:0] count_t;

    // Word index into the SRAM
    typedef logic [IMEM_AW-1:0] imem_idx_t;

    ////////////////////////////////////////
    // Reset values
    ////////////////////////////////////////

    // One word below the boot address
    // First sequential fetch lands on 0x1C000000, SRAM index 0
    localparam pc_t RESET_PC = 32'h1BFF_FFFC;

    ////////////////////////////////////////
    // Fetch controller states
    ////////////////////////////////////////

    typedef enum logic [1:0] {
        HALTED,
        RUNNING,
        DRAINING
    } fetch_state_t;

endpackage

/* src/if_stage.sv */
`timescale 1ns/1ns

module if_stage (
    input  logic            clk,
    input  logic            resetn,
    // From fetch controller
    input  logic            fetch_en,
    // Decode side handshake and redirect
    input  logic            id_allowin,
    input  logic            br_taken,
    input  fetch_pkg::pc_t  br_target,
    // Instruction SRAM
    output logic            sram_en,
    output fetch_pkg::pc_t  sram_addr,
    input  fetch_pkg::inst_t sram_rdata,
    // To decode
    output logic            if_valid_out,
    output fetch_pkg::pc_t  if_pc,
    output fetch_pkg::inst_t if_inst
);

    logic           if_valid;
    logic           if_allowin;
    logic           if_accept;
    fetch_pkg::pc_t seq_pc;
    fetch_pkg::pc_t next_pc;

    // Redirect that could not be taken yet
    logic           redir_pending;
    fetch_pkg::pc_t redir_target;

    ////////////////////////////////////////
    // Handshake
    ////////////////////////////////////////

    // Stage is free when empty or when decode takes the held entry
    assign if_allowin   = ~if_valid | id_allowin;

    // New PC only while the controller lets fetch run
    assign if_accept    = if_allowin & fetch_en;

    assign if_valid_out = if_valid;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            if_valid <= 1'b0;
        end else if (if_allowin) begin
            // Cleared too when the controller stops fetching
            if_valid <= fetch_en;
        end else if (br_taken) begin
            // Held instruction is on the wrong path
            if_valid <= 1'b0;
        end
    end

    ////////////////////////////////////////
    // Next PC
    ////////////////////////////////////////

    assign seq_pc  = if_pc + 32'd4;

    // Live redirect wins over a stored one
    assign next_pc = br_taken      ? br_target    :
                     redir_pending ? redir_target :
                                     seq_pc;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            if_pc <= fetch_pkg::RESET_PC;
        end else if (if_accept) begin
            if_pc <= next_pc;
        end
    end

    ////////////////////////////////////////
    // Deferred redirect
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!resetn) begin
            redir_pending <= 1'b0;
        end else if (if_accept) begin
            // Consumed by this accept, or superseded by br_taken
            redir_pending <= 1'b0;
        end else if (br_taken) begin
            redir_pending <= 1'b1;
        end
    end

    // Target register, payload only
    always_ff @(posedge clk) begin
        if (br_taken && !if_accept) begin
            redir_target <= br_target;
        end
    end

    // SRAM read follows the PC update
    assign sram_en   = if_accept;
    assign sram_addr = next_pc;

    // Read data is held by the SRAM while stalled
    assign if_inst   = sram_rdata;

endmodule

/* src/inst_sram.sv */
`timescale 1ns/1ns

module inst_sram (
    input  logic                 clk,
    // Fetch read port
    input  logic                 en,
    input  fetch_pkg::pc_t       addr,
    output fetch_pkg::inst_t     rdata,
    // Program load port
    input  logic                 load_en,
    input  fetch_pkg::imem_idx_t load_idx,
    input  fetch_pkg::inst_t     load_data
);

    ////////////////////////////////////////
    // Storage
    ////////////////////////////////////////

    fetch_pkg::inst_t     mem [fetch_pkg::IMEM_DEPTH];

    // Word address modulo depth
    fetch_pkg::imem_idx_t rd_idx;

    // Byte offset bits dropped
    assign rd_idx = addr[fetch_pkg::IMEM_AW+1:2];

    ////////////////////////////////////////
    // Load port
    ////////////////////////////////////////

    // Only used while fetch is halted
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_idx] <= load_data;
        end
    end

    ////////////////////////////////////////
    // Read port
    ////////////////////////////////////////

    // One cycle latency
    // Output keeps the last word while en is low
    always_ff @(posedge clk) begin
        if (en) begin
            rdata <= mem[rd_idx];
        end
    end

endmodule

/* src/fetch_ctrl.sv */
`timescale 1ns/1ns

module fetch_ctrl (
    input  logic clk,
    input  logic resetn,
    // Software control
    input  logic start,
    input  logic halt_req,
    // Stage occupancy
    input  logic if_valid_out,
    // To IF stage
    output logic fetch_en,
    // Status
    output logic halted
);

    fetch_pkg::fetch_state_t state;
    fetch_pkg::fetch_state_t state_next;

    ////////////////////////////////////////
    // Next state
    ////////////////////////////////////////

    always_comb begin
        state_next = state;
        case (state)
            fetch_pkg::HALTED: begin
                if (start) begin
                    state_next = fetch_pkg::RUNNING;
                end
            end
            fetch_pkg::RUNNING: begin
                // Stop new requests, let the held one leave
                if (halt_req) begin
                    state_next = fetch_pkg::DRAINING;
                end
            end
            fetch_pkg::DRAINING: begin
                // Stage empty, nothing left in flight
                if (!if_valid_out) begin
                    state_next = fetch_pkg::HALTED;
                end
            end
            default: begin
                state_next = fetch_pkg::HALTED;
            end
        endcase
    end

    ////////////////////////////////////////
    // State and status registers
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= fetch_pkg::HALTED;
        end else begin
            state <= state_next;
        end
    end

    // Rises with the state, marks end of drain
    always_ff @(posedge clk) begin
        if (!resetn) begin
            halted <= 1'b1;
        end else begin
            halted <= (state_next == fetch_pkg::HALTED);
        end
    end

    ////////////////////////////////////////
    // Outputs
    ////////////////////////////////////////

    // New fetches only while running
    assign fetch_en = (state == fetch_pkg::RUNNING);

endmodule

/* src/fetch_counter.sv */
`timescale 1ns/1ns

module fetch_counter (
    input  logic              clk,
    input  logic              resetn,
    // Observed handshake
    input  logic              if_valid_out,
    input  logic              id_allowin,
    input  logic              br_taken,
    // Counter values
    output fetch_pkg::count_t inst_count,
    output fetch_pkg::count_t redirect_count
);

    logic xfer;

    // Instruction handed to decode this cycle
    assign xfer = if_valid_out & id_allowin;

    ////////////////////////////////////////
    // Delivered instructions
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!resetn) begin
            inst_count <= '0;
        end else if (xfer) begin
            // Wraps at 2^32
            inst_count <= inst_count + 32'd1;
        end
    end

    ////////////////////////////////////////
    // Redirect pulses
    ////////////////////////////////////////

    // Counts every pulse, taken now or deferred
    always_ff @(posedge clk) begin
        if (!resetn) begin
            redirect_count <= '0;
        end else if (br_taken) begin
            redirect_count <= redirect_count + 32'd1;
        end
    end

endmodule

/* src/fetch_top.sv */
`timescale 1ns/1ns

module fetch_top (
    input  logic                 clk,
    input  logic                 resetn,
    // Run control
    input  logic                 start,
    input  logic                 halt_req,
    // Decode side
    input  logic                 id_allowin,
    input  logic                 br_taken,
    input  fetch_pkg::pc_t       br_target,
    // Program load
    input  logic                 load_en,
    input  fetch_pkg::imem_idx_t load_idx,
    input  fetch_pkg::inst_t     load_data,
    // Fetched instruction
    output logic                 if_valid_out,
    output fetch_pkg::pc_t       if_pc,
    output fetch_pkg::inst_t     if_inst,
    // Status and counters
    output logic                 halted,
    output fetch_pkg::count_t    inst_count,
    output fetch_pkg::count_t    redirect_count
);

    // Controller gate
    logic             fetch_en;

    // Stage to SRAM
    logic             sram_en;
    fetch_pkg::pc_t   sram_addr;
    fetch_pkg::inst_t sram_rdata;

    ////////////////////////////////////////
    // Fetch pipeline
    ////////////////////////////////////////

    if_stage i_if_stage (
        .clk          (clk),
        .resetn       (resetn),
        .fetch_en     (fetch_en),
        .id_allowin   (id_allowin),
        .br_taken     (br_taken),
        .br_target    (br_target),
        .sram_en      (sram_en),
        .sram_addr    (sram_addr),
        .sram_rdata   (sram_rdata),
        .if_valid_out (if_valid_out),
        .if_pc        (if_pc),
        .if_inst      (if_inst)
    );

    inst_sram i_inst_sram (
        .clk       (clk),
        .en        (sram_en),
        .addr      (sram_addr),
        .rdata     (sram_rdata),
        .load_en   (load_en),
        .load_idx  (load_idx),
        .load_data (load_data)
    );

    ////////////////////////////////////////
    // Control and monitoring
    ////////////////////////////////////////

    fetch_ctrl i_fetch_ctrl (
        .clk          (clk),
        .resetn       (resetn),
        .start        (start),
        .halt_req     (halt_req),
        .if_valid_out (if_valid_out),
        .fetch_en     (fetch_en),
        .halted       (halted)
    );

    fetch_counter i_fetch_counter (
        .clk            (clk),
        .resetn         (resetn),
        .if_valid_out   (if_valid_out),
        .id_allowin     (id_allowin),
        .br_taken       (br_taken),
        .inst_count     (inst_count),
        .redirect_count (redirect_count)
    );

endmodule

/* test/tb_fetch.sv */
`timescale 1ns/1ns

module tb_fetch;

    // First fetched address at SRAM index 0
    localparam fetch_pkg::pc_t BOOT_PC = 32'h1C00_0000;

    logic                 clk = 1'b0;
    logic                 resetn;
    logic                 start;
    logic                 halt_req;
    logic                 id_allowin;
    logic                 br_taken;
    fetch_pkg::pc_t       br_target;
    logic                 load_en;
    fetch_pkg::imem_idx_t load_idx;
    fetch_pkg::inst_t     load_data;
    logic                 if_valid_out;
    fetch_pkg::pc_t       if_pc;
    fetch_pkg::inst_t     if_inst;
    logic                 halted;
    fetch_pkg::count_t    inst_count;
    fetch_pkg::count_t    redirect_count;

    // Copy of the loaded program
    fetch_pkg::inst_t mirror [fetch_pkg::IMEM_DEPTH];

    // Reference model
    fetch_pkg::pc_t   exp_pc;
    fetch_pkg::pc_t   last_pc;
    fetch_pkg::pc_t   hold_pc;
    fetch_pkg::inst_t hold_inst;
    logic             hold_check;

    int  xfer_tally = 0;
    int  br_tally = 0;
    int  stalled_redirects = 0;
    int  stall_cycles = 0;
    int  error_count = 0;
    int  tests_run = 0;
    int  tests_failed = 0;
    bit  aborted = 1'b0;

    always #2 clk = ~clk;

    fetch_top i_fetch_top (
        .clk            (clk),
        .resetn         (resetn),
        .start          (start),
        .halt_req       (halt_req),
        .id_allowin     (id_allowin),
        .br_taken       (br_taken),
        .br_target      (br_target),
        .load_en        (load_en),
        .load_idx       (load_idx),
        .load_data      (load_data),
        .if_valid_out   (if_valid_out),
        .if_pc          (if_pc),
        .if_inst        (if_inst),
        .halted         (halted),
        .inst_count     (inst_count),
        .redirect_count (redirect_count)
    );

    ////////////////////////////////////////
    // Reporting and waits
    ////////////////////////////////////////

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        error_count++;
        $display("mismatch at %0t ns: %s expected 0x%08h got 0x%08h",
                 $time, name, expected, actual);
    endtask

    task automatic report_failure(input string msg);
        error_count++;
        $display("error at %0t ns: %s", $time, msg);
    endtask

    task automatic timed_out(input string what);
        report_failure($sformatf("timeout waiting for %s, fetch state %s", what,
                                 i_fetch_top.i_fetch_ctrl.state.name()));
        aborted = 1'b1;
    endtask

    // Inputs change 1 ns after the edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic drive_allowin(input int stall_pct);
        id_allowin = (($urandom % 100) >= stall_pct);
    endtask

    task automatic wait_transfers(input int count, input int limit, input int stall_pct,
                                  input string what);
        int target;
        int cycles;
        target = xfer_tally + count;
        cycles = 0;
        while (xfer_tally < target && cycles < limit) begin
            next_cycle();
            drive_allowin(stall_pct);
            cycles++;
        end
        if (xfer_tally < target) begin
            timed_out(what);
        end
    endtask

    task automatic wait_valid(input int limit);
        int cycles;
        cycles = 0;
        while (!if_valid_out && cycles < limit) begin
            next_cycle();
            cycles++;
        end
        if (!if_valid_out) begin
            timed_out("if_valid_out");
        end
    endtask

    task automatic wait_halted(input int limit, input int stall_pct);
        int cycles;
        cycles = 0;
        while (!halted && cycles < limit) begin
            next_cycle();
            drive_allowin(stall_pct);
            cycles++;
        end
        if (!halted) begin
            timed_out("halted");
        end
    endtask

    ////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////

    task automatic pulse_start();
        start = 1'b1;
        next_cycle();
        start = 1'b0;
    endtask

    task automatic request_halt();
        halt_req = 1'b1;
        next_cycle();
        halt_req = 1'b0;
    endtask

    task automatic pulse_redirect(input fetch_pkg::pc_t target);
        br_taken  = 1'b1;
        br_target = target;
        next_cycle();
        br_taken  = 1'b0;
    endtask

    // Word aligned inside the SRAM window
    function automatic fetch_pkg::pc_t random_target();
        return BOOT_PC + (($urandom % fetch_pkg::IMEM_DEPTH) << 2);
    endfunction

    task automatic load_program();
        for (int i = 0; i < fetch_pkg::IMEM_DEPTH; i++) begin
            load_en   = 1'b1;
            load_idx  = fetch_pkg::imem_idx_t'(i);
            load_data = $urandom;
            mirror[i] = load_data;
            next_cycle();
        end
        load_en = 1'b0;
    endtask

    task automatic check_idle_outputs();
        assert (if_valid_out == 1'b0)
            else report_mismatch("if_valid_out", 32'd0, {31'd0, if_valid_out});
        assert (halted == 1'b1)
            else report_mismatch("halted", 32'd1, {31'd0, halted});
        assert (inst_count == 32'd0)
            else report_mismatch("inst_count", 32'd0, inst_count);
        assert (redirect_count == 32'd0)
            else report_mismatch("redirect_count", 32'd0, redirect_count);
    endtask

    task automatic finish_test(input string name, input int err_start);
        int errs;
        errs = error_count - err_start;
        tests_run++;
        if (errs == 0) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: FAILED with %0d errors", name, errs);
        end
    endtask

    ////////////////////////////////////////
    // Model and checks
    ////////////////////////////////////////

    // Samples at the edge before the DUT registers move
    always @(posedge clk) begin
        if (!resetn) begin
            exp_pc     = BOOT_PC;
            hold_check = 1'b0;
        end else begin
            // Entry held by decode must not move
            if (hold_check) begin
                assert (if_pc == hold_pc)
                    else report_mismatch("if_pc during stall", hold_pc, if_pc);
                assert (if_inst == hold_inst)
                    else report_mismatch("if_inst during stall", hold_inst, if_inst);
            end
            // Transfer to decode
            if (if_valid_out && id_allowin) begin
                assert (if_pc == exp_pc)
                    else report_mismatch("if_pc", exp_pc, if_pc);
                assert (if_inst == mirror[exp_pc[fetch_pkg::IMEM_AW+1:2]])
                    else report_mismatch("if_inst", mirror[exp_pc[fetch_pkg::IMEM_AW+1:2]],
                                         if_inst);
                xfer_tally++;
                last_pc = if_pc;
                exp_pc  = exp_pc + 32'd4;
            end
            // Redirect after any transfer in the same cycle
            if (br_taken) begin
                if (if_valid_out && !id_allowin) begin
                    stalled_redirects++;
                end
                br_tally++;
                exp_pc = br_target;
            end
            if (if_valid_out && !id_allowin) begin
                stall_cycles++;
            end
            hold_check = if_valid_out && !id_allowin && !br_taken;
            hold_pc    = if_pc;
            hold_inst  = if_inst;
        end
    end

    // No instruction while halted
    assert property (@(posedge clk) disable iff (!resetn) halted |-> !if_valid_out)
        else report_mismatch("if_valid_out while halted", 32'd0, 32'd1);

    // Stalled entry survives unless a redirect drops it
    assert property (@(posedge clk) disable iff (!resetn)
        (if_valid_out && !id_allowin && !br_taken) |=> if_valid_out)
        else report_mismatch("if_valid_out after stall", 32'd1, 32'd0);

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////

    initial begin
        int             err_start;
        fetch_pkg::pc_t halt_pc;

        void'($urandom(10673));
        resetn     = 1'b0;
        start      = 1'b0;
        halt_req   = 1'b0;
        id_allowin = 1'b1;
        br_taken   = 1'b0;
        br_target  = '0;
        load_en    = 1'b0;
        load_idx   = '0;
        load_data  = '0;

        // Idle outputs during and after reset
        err_start = error_count;
        for (int i = 0; i < 16; i++) begin
            next_cycle();
            check_idle_outputs();
        end
        resetn = 1'b1;
        next_cycle();
        check_idle_outputs();
        finish_test("reset", err_start);

        load_program();

        // Sequential stream from the boot address
        err_start = error_count;
        pulse_start();
        assert (halted == 1'b0)
            else report_mismatch("halted after start", 32'd0, {31'd0, halted});
        wait_transfers(32, 100, 0, "sequential transfers");
        finish_test("sequential", err_start);

        // Random decode stalls
        if (!aborted) begin
            err_start = error_count;
            for (int n = 0; n < 300; n++) begin
                drive_allowin(50);
                next_cycle();
            end
            id_allowin = 1'b1;
            wait_transfers(4, 20, 0, "transfers after back-pressure");
            if (stall_cycles == 0) begin
                report_failure("decode never stalled a valid instruction");
            end
            finish_test("backpressure", err_start);
        end

        // Even rounds hit an accepting cycle and odd rounds a stalled one
        if (!aborted) begin
            err_start = error_count;
            for (int k = 0; k < 8; k++) begin
                id_allowin = (k % 2 == 0);
                wait_valid(20);
                pulse_redirect(random_target());
                if (k % 2 != 0) begin
                    next_cycle();
                    next_cycle();
                end
                wait_transfers(3, 100, (k % 2 == 0) ? 0 : 30, "transfers after redirect");
            end
            if (stalled_redirects == 0) begin
                report_failure("no redirect met a stalled instruction");
            end
            finish_test("redirect", err_start);
        end

        // Drain under stalls and resume sequentially
        if (!aborted) begin
            err_start = error_count;
            wait_transfers(5, 50, 40, "transfers before halt");
            request_halt();
            wait_halted(100, 50);
            halt_pc = last_pc;
            for (int n = 0; n < 10; n++) begin
                drive_allowin(50);
                next_cycle();
            end
            id_allowin = 1'b1;
            pulse_start();
            wait_transfers(1, 20, 0, "first transfer after resume");
            assert (last_pc == halt_pc + 32'd4)
                else report_mismatch("if_pc after resume", halt_pc + 32'd4, last_pc);
            finish_test("halt_resume", err_start);
        end

        // Counters against the tallies once fetch is quiet
        if (!aborted) begin
            err_start = error_count;
            request_halt();
            wait_halted(100, 0);
            next_cycle();
            assert (inst_count == fetch_pkg::count_t'(xfer_tally))
                else report_mismatch("inst_count", xfer_tally, inst_count);
            assert (redirect_count == fetch_pkg::count_t'(br_tally))
                else report_mismatch("redirect_count", br_tally, redirect_count);
            finish_test("counters", err_start);
        end

        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, error_count);
        if (error_count == 0 && !aborted) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* build.f */
src/fetch_pkg.sv
src/if_stage.sv
src/inst_sram.sv
src/fetch_ctrl.sv
src/fetch_counter.sv
src/fetch_top.sv
test/tb_fetch.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build tb_fetch with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module tb_fetch -f build.f -Mdir obj_dir
	@out=$$(./obj_dir/Vtb_fetch); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir
